// ==== src/cpuDefsPkg.sv ====
package cpuDefsPkg;

    // Machine sizes
    localparam int DataWidth = 16;
    localparam int RegCount = 16;
    localparam int RegAddrWidth = $clog2(RegCount);
    localparam int InstrAddrWidth = 8;
    localparam int InstrWidth = 16;

    // Shift amount taken from the low bits of an operand
    localparam int ShamtWidth = $clog2(DataWidth);

    typedef logic [DataWidth-1:0] dataWord;
    typedef logic [RegAddrWidth-1:0] regAddr;
    typedef logic [InstrAddrWidth-1:0] instrAddr;
    typedef logic [InstrWidth-1:0] instrWord;

endpackage

// ==== src/isaPkg.sv ====
package isaPkg;

    import cpuDefsPkg::*;

    // Instruction field positions
    localparam int OpMsb = 15;
    localparam int OpLsb = 12;
    localparam int RdMsb = 11;
    localparam int RdLsb = 8;
    localparam int RsMsb = 7;
    localparam int RsLsb = 4;
    localparam int RtMsb = 3;
    localparam int RtLsb = 0;
    localparam int ImmMsb = 7;
    localparam int ImmLsb = 0;

    // Codes 12 to 15 are unused and behave as NOP
    typedef enum logic [3:0] {
        OpNop = 4'd0,
        OpAdd = 4'd1,
        OpSub = 4'd2,
        OpAnd = 4'd3,
        OpOr  = 4'd4,
        OpXor = 4'd5,
        OpShl = 4'd6,
        OpShr = 4'd7,
        OpLdi = 4'd8,
        OpLui = 4'd9,
        OpJal = 4'd10,
        OpBnz = 4'd11
    } opcode;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluShl,
        AluShr,
        AluPassA,
        AluPassB
    } aluOp;

    typedef struct packed {
        logic    valid;
        logic    writeEn;
        logic    isBranch;
        aluOp    op;
        dataWord opA;
        dataWord opB;
        regAddr  rd;
    } issueRecord;

    typedef struct packed {
        logic    en;
        regAddr  addr;
        dataWord data;
    } regWrite;

    typedef struct packed {
        logic     load;
        instrAddr target;
    } pcRedirect;

    typedef enum logic {
        Run,
        BranchWait
    } ctrlState;

endpackage

// ==== src/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit import cpuDefsPkg::*, isaPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      run,
    input  pcRedirect redirect,
    input  logic      holdPc,
    input  logic      squashFetch,
    input  instrWord  instrIn,
    output instrAddr  pc,
    output instrWord  fetched,
    output instrAddr  fetchedPc,
    output logic      fetchValid
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            fetchValid <= 1'b0;
        end else if (run) begin
            if (redirect.load) begin
                pc <= redirect.target;
            end else if (!holdPc) begin
                pc <= pc + 1'b1;
            end
            fetchValid <= !squashFetch;
        end
    end

    // Fetch register payload, a bubble reads as NOP
    always_ff @(posedge clk) begin
        if (run) begin
            fetched <= squashFetch ? '0 : instrIn;
            fetchedPc <= pc;
        end
    end

endmodule

// ==== src/pipelineControl.sv ====
`timescale 1ns/1ps

module pipelineControl import cpuDefsPkg::*, isaPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      run,
    input  logic      isJump,
    input  logic      isBranch,
    input  instrAddr  jumpTarget,
    input  logic      branchTaken,
    input  instrAddr  branchTarget,
    output pcRedirect redirect,
    output logic      holdPc,
    output logic      squashFetch
);

    ctrlState state;
    ctrlState stateNext;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Run;
        end else if (run) begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        redirect = '0;
        holdPc = 1'b0;
        squashFetch = 1'b0;
        case (state)
            Run: begin
                if (isJump) begin
                    redirect.load = 1'b1;
                    redirect.target = jumpTarget;
                    squashFetch = 1'b1;
                end else if (isBranch) begin
                    // Park the PC at branch+1 until execute resolves it
                    holdPc = 1'b1;
                    squashFetch = 1'b1;
                    stateNext = BranchWait;
                end
            end
            BranchWait: begin
                // Not taken simply resumes from branch+1
                if (branchTaken) begin
                    redirect.load = 1'b1;
                    redirect.target = branchTarget;
                    squashFetch = 1'b1;
                end
                stateNext = Run;
            end
            default: stateNext = Run;
        endcase
    end

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder import cpuDefsPkg::*, isaPkg::*; (
    input  instrWord   fetched,
    input  instrAddr   fetchedPc,
    input  logic       fetchValid,
    input  dataWord    readDataA,
    input  dataWord    readDataB,
    output regAddr     readAddrA,
    output regAddr     readAddrB,
    output issueRecord issue,
    output logic       isJump,
    output logic       isBranch,
    output instrAddr   jumpTarget
);

    opcode code;
    logic [ImmMsb:ImmLsb] imm;
    instrAddr linkAddr;

    assign code = opcode'(fetched[OpMsb:OpLsb]);
    assign imm = fetched[ImmMsb:ImmLsb];
    assign linkAddr = fetchedPc + 1'b1;

    assign readAddrA = fetched[RsMsb:RsLsb];
    assign readAddrB = fetched[RtMsb:RtLsb];

    assign isJump = fetchValid && (code == OpJal);
    assign isBranch = fetchValid && (code == OpBnz);
    assign jumpTarget = instrAddr'(imm);

    always_comb begin
        issue.valid = fetchValid;
        issue.writeEn = 1'b1;
        issue.isBranch = 1'b0;
        issue.op = AluPassB;
        issue.opA = readDataA;
        issue.opB = readDataB;
        issue.rd = fetched[RdMsb:RdLsb];
        case (code)
            OpNop: issue.writeEn = 1'b0;
            OpAdd: issue.op = AluAdd;
            OpSub: issue.op = AluSub;
            OpAnd: issue.op = AluAnd;
            OpOr:  issue.op = AluOr;
            OpXor: issue.op = AluXor;
            OpShl: issue.op = AluShl;
            OpShr: issue.op = AluShr;
            OpLdi: issue.opB = dataWord'(imm);
            OpLui: issue.opB = dataWord'(imm) << (DataWidth / 2);
            OpJal: begin
                // Link value rides in operand A
                issue.op = AluPassA;
                issue.opA = dataWord'(linkAddr);
            end
            OpBnz: begin
                issue.writeEn = 1'b0;
                issue.isBranch = 1'b1;
            end
            default: begin
                issue.valid = 1'b0;
                issue.writeEn = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ps

module registerFile import cpuDefsPkg::*, isaPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regAddr  readAddrA,
    input  regAddr  readAddrB,
    output dataWord readDataA,
    output dataWord readDataB,
    input  regWrite wb
);

    dataWord regs [RegCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Bypass the write in flight so decode sees the execute result
    assign readDataA = (wb.en && (wb.addr == readAddrA)) ? wb.data : regs[readAddrA];
    assign readDataB = (wb.en && (wb.addr == readAddrB)) ? wb.data : regs[readAddrB];

endmodule

// ==== src/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit import cpuDefsPkg::*, isaPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       run,
    input  issueRecord issue,
    output regWrite    wb,
    output logic       branchTaken,
    output instrAddr   branchTarget
);

    issueRecord issueReg;
    dataWord result;

    always_ff @(posedge clk) begin
        if (rst) begin
            issueReg <= '0;
        end else if (run) begin
            issueReg <= issue;
        end
    end

    always_comb begin
        case (issueReg.op)
            AluAdd:   result = issueReg.opA + issueReg.opB;
            AluSub:   result = issueReg.opA - issueReg.opB;
            AluAnd:   result = issueReg.opA & issueReg.opB;
            AluOr:    result = issueReg.opA | issueReg.opB;
            AluXor:   result = issueReg.opA ^ issueReg.opB;
            AluShl:   result = issueReg.opA << issueReg.opB[ShamtWidth-1:0];
            AluShr:   result = issueReg.opA >> issueReg.opB[ShamtWidth-1:0];
            AluPassA: result = issueReg.opA;
            default:  result = issueReg.opB;
        endcase
    end

    assign wb.en = issueReg.valid && issueReg.writeEn && run;
    assign wb.addr = issueReg.rd;
    assign wb.data = result;

    // BNZ tests rs and jumps to the low byte of rt
    assign branchTaken = issueReg.valid && issueReg.isBranch && (issueReg.opA != '0);
    assign branchTarget = issueReg.opB[InstrAddrWidth-1:0];

endmodule

// ==== src/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore import cpuDefsPkg::*, isaPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     run,
    output instrAddr instrAddrOut,
    input  instrWord instrIn,
    output logic     wbEn,
    output regAddr   wbAddr,
    output dataWord  wbData
);

    instrAddr pc;
    instrWord fetched;
    instrAddr fetchedPc;
    logic fetchValid;

    pcRedirect redirect;
    logic holdPc;
    logic squashFetch;

    regAddr readAddrA;
    regAddr readAddrB;
    dataWord readDataA;
    dataWord readDataB;

    issueRecord issue;
    logic isJump;
    logic isBranch;
    instrAddr jumpTarget;

    regWrite wb;
    logic branchTaken;
    instrAddr branchTarget;

    assign instrAddrOut = pc;
    assign wbEn = wb.en;
    assign wbAddr = wb.addr;
    assign wbData = wb.data;

    fetchUnit fetch (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .redirect   (redirect),
        .holdPc     (holdPc),
        .squashFetch(squashFetch),
        .instrIn    (instrIn),
        .pc         (pc),
        .fetched    (fetched),
        .fetchedPc  (fetchedPc),
        .fetchValid (fetchValid)
    );

    pipelineControl control (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .isJump      (isJump),
        .isBranch    (isBranch),
        .jumpTarget  (jumpTarget),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget),
        .redirect    (redirect),
        .holdPc      (holdPc),
        .squashFetch (squashFetch)
    );

    instrDecoder decoder (
        .fetched   (fetched),
        .fetchedPc (fetchedPc),
        .fetchValid(fetchValid),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .issue     (issue),
        .isJump    (isJump),
        .isBranch  (isBranch),
        .jumpTarget(jumpTarget)
    );

    registerFile regFile (
        .clk      (clk),
        .rst      (rst),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .wb       (wb)
    );

    executeUnit execute (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .issue       (issue),
        .wb          (wb),
        .branchTaken (branchTaken),
        .branchTarget(branchTarget)
    );

endmodule

// ==== tb/cpuCoreTb.sv ====
`timescale 1ns/1ps

module cpuCoreTb import cpuDefsPkg::*, isaPkg::*;;

    logic clk;
    logic rst;
    logic run;
    instrAddr instrAddrOut;
    instrWord instrIn;
    logic wbEn;
    regAddr wbAddr;
    dataWord wbData;

    instrWord imem [1 << InstrAddrWidth];
    logic [RegAddrWidth+DataWidth-1:0] expected [$];
    logic [RegAddrWidth+DataWidth-1:0] got;
    logic [31:0] lfsrState;
    logic checking;
    string testName;
    int errors;
    int testCount;
    int failedTests;

    assign instrIn = imem[instrAddrOut];

    cpuCore UUT (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .instrAddrOut(instrAddrOut),
        .instrIn     (instrIn),
        .wbEn        (wbEn),
        .wbAddr      (wbAddr),
        .wbData      (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] randBits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            r = {r[14:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic instrWord regOp(input logic [3:0] op, input regAddr rd, rs, rt);
        return {op, rd, rs, rt};
    endfunction

    function automatic instrWord immOp(input logic [3:0] op, input regAddr rd,
                                       input logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    task automatic clearMemory;
        for (int a = 0; a < (1 << InstrAddrWidth); a++) begin
            // Unused code 15 acts as NOP with the address in the low byte
            imem[a] = {4'hf, 4'h0, 8'(a)};
        end
    endtask

    // Sequential ISA model stepping one instruction at a time
    task automatic modelProgram;
        dataWord r [RegCount];
        instrAddr pc;
        instrWord ins;
        dataWord a;
        dataWord b;
        dataWord v;
        logic wr;
        int steps;
        expected.delete();
        for (int i = 0; i < RegCount; i++) begin
            r[i] = '0;
        end
        pc = '0;
        steps = 0;
        // Test programs sit low in memory and never loop back
        while (pc < 8'd240 && steps < 400) begin
            ins = imem[pc];
            a = r[ins[7:4]];
            b = r[ins[3:0]];
            pc = pc + 8'd1;
            wr = 1'b1;
            v = '0;
            case (ins[15:12])
                4'd1: v = a + b;
                4'd2: v = a - b;
                4'd3: v = a & b;
                4'd4: v = a | b;
                4'd5: v = a ^ b;
                4'd6: v = a << b[3:0];
                4'd7: v = a >> b[3:0];
                4'd8: v = {8'h00, ins[7:0]};
                4'd9: v = {ins[7:0], 8'h00};
                4'd10: begin
                    v = {8'h00, pc};
                    pc = ins[7:0];
                end
                4'd11: begin
                    wr = 1'b0;
                    if (a != '0) begin
                        pc = b[7:0];
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                r[ins[11:8]] = v;
                expected.push_back({ins[11:8], v});
            end
            steps++;
        end
    endtask

    task automatic loadDirected(input int which);
        clearMemory();
        case (which)
            0: begin
                imem[0] = immOp(OpLdi, 4'd1, 8'h5a);
                imem[1] = immOp(OpLdi, 4'd2, 8'h03);
                imem[2] = regOp(OpAdd, 4'd3, 4'd1, 4'd2);
                imem[3] = regOp(OpSub, 4'd4, 4'd3, 4'd2);
                imem[4] = regOp(OpAnd, 4'd5, 4'd4, 4'd3);
                imem[5] = regOp(OpOr, 4'd6, 4'd5, 4'd2);
                imem[6] = regOp(OpXor, 4'd7, 4'd6, 4'd4);
                imem[7] = regOp(OpShl, 4'd8, 4'd7, 4'd2);
                imem[8] = regOp(OpShr, 4'd9, 4'd8, 4'd2);
                imem[9] = regOp(OpSub, 4'd10, 4'd2, 4'd1);
            end
            1: begin
                imem[0] = immOp(OpLdi, 4'd1, 8'h34);
                imem[1] = immOp(OpLui, 4'd2, 8'h12);
                imem[2] = regOp(OpOr, 4'd3, 4'd1, 4'd2);
                imem[3] = immOp(OpLui, 4'd4, 8'hff);
                imem[4] = regOp(OpOr, 4'd5, 4'd4, 4'd3);
            end
            2: begin
                imem[0] = immOp(OpLdi, 4'd1, 8'h07);
                imem[1] = immOp(OpJal, 4'd2, 8'h04);
                imem[2] = immOp(OpLdi, 4'd3, 8'h11);
                imem[3] = immOp(OpLdi, 4'd4, 8'h22);
                imem[4] = regOp(OpAdd, 4'd5, 4'd2, 4'd1);
            end
            default: begin
                imem[0] = immOp(OpLdi, 4'd1, 8'h05);
                imem[1] = immOp(OpLdi, 4'd2, 8'h01);
                imem[2] = regOp(OpBnz, 4'd0, 4'd2, 4'd1);
                imem[3] = immOp(OpLdi, 4'd3, 8'haa);
                imem[4] = immOp(OpLdi, 4'd4, 8'hbb);
                imem[5] = immOp(OpLdi, 4'd5, 8'h00);
                imem[6] = regOp(OpBnz, 4'd0, 4'd5, 4'd1);
                imem[7] = immOp(OpLdi, 4'd6, 8'h55);
                imem[8] = regOp(OpAdd, 4'd7, 4'd6, 4'd2);
            end
        endcase
    endtask

    task automatic loadRandomProgram;
        logic [3:0] op;
        clearMemory();
        for (int i = 0; i < 24; i++) begin
            // ALU ops, LDI and LUI only
            op = 4'(1 + (randBits(4) % 9));
            imem[i] = {op, 12'(randBits(12))};
        end
    endtask

    task automatic applyReset;
        @(posedge clk);
        rst <= 1'b1;
        run <= 1'b1;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 4) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            assert (wbEn == 1'b0) else begin
                $display("ERROR %s: write strobe high during reset", testName);
                errors++;
            end
        end
        assert (instrAddrOut == '0) else begin
            $display("FAIL %s: expected address %h, actual %h", testName, 8'h00, instrAddrOut);
            errors++;
        end
    endtask

    task automatic awaitWrites(input logic randomRun);
        int cycles;
        cycles = 0;
        while (expected.size() != 0 && cycles < 2000) begin
            @(posedge clk);
            run <= randomRun ? (randBits(2) != 16'd0) : 1'b1;
            cycles++;
        end
        run <= 1'b1;
        if (expected.size() != 0) begin
            $display("ERROR %s: timed out with %0d writes missing", testName, expected.size());
            errors++;
        end
    endtask

    task automatic runTest(input string name, input logic randomRun);
        int errorsBefore;
        testName = name;
        errorsBefore = errors;
        modelProgram();
        applyReset();
        checking = 1'b1;
        awaitWrites(randomRun);
        // Quiet tail catches stray writes after the last one
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
        end
        checking = 1'b0;
        testCount++;
        if (errors == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            failedTests++;
            $display("test %s: %0d errors", name, errors - errorsBefore);
        end
    endtask

    // Writes are compared in order against the model
    always @(negedge clk) begin
        if (checking) begin
            if (!run) begin
                assert (wbEn == 1'b0) else begin
                    $display("ERROR %s: register write while run is low", testName);
                    errors++;
                end
            end
            if (wbEn) begin
                got = {wbAddr, wbData};
                assert (expected.size() != 0) else begin
                    $display("ERROR %s: unexpected write r%0d=%h", testName, wbAddr, wbData);
                    errors++;
                end
                if (expected.size() != 0) begin
                    assert (got == expected[0]) else begin
                        $display("FAIL %s: expected r%0d=%h, actual r%0d=%h", testName,
                                 expected[0][19:16], expected[0][15:0], wbAddr, wbData);
                        errors++;
                    end
                    void'(expected.pop_front());
                end
            end
        end
    end

    initial begin
        rst = 1'b1;
        run = 1'b1;
        checking = 1'b0;
        errors = 0;
        testCount = 0;
        failedTests = 0;
        lfsrState = 32'hd659bb9d;
        testName = "reset";
        loadDirected(0);
        // Let the core run so reset lands on writes in flight
        @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        runTest("reset", 1'b0);
        loadDirected(0);
        runTest("alu chain", 1'b0);
        loadDirected(1);
        runTest("immediates", 1'b0);
        loadDirected(2);
        runTest("jump and link", 1'b0);
        loadDirected(3);
        runTest("branches", 1'b0);
        for (int p = 0; p < 4; p++) begin
            loadRandomProgram();
            runTest($sformatf("random %0d", p), 1'b1);
        end
        $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/cpuDefsPkg.sv
src/isaPkg.sv
src/fetchUnit.sv
src/pipelineControl.sv
src/instrDecoder.sv
src/registerFile.sv
src/executeUnit.sv
src/cpuCore.sv
tb/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module cpuCoreTb -f files.f
./obj_dir/VcpuCoreTb > sim.log
cat sim.log
if grep -qx "TB PASSED" sim.log; then
    exit 0
fi
exit 1
